// File: rtl/soc_mem_pkg.sv
/*
  Shared address map and widths for the data memory and the UART transmit queue.
  The transmit buffer must start on a 256-byte boundary, because the buffer
  index is taken straight from the low address bits.
  Queue indices are qidx_w bits wide and wrap modulo buf_depth.
*/
package soc_mem_pkg;

    // CPU bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // One serial character
    localparam int byte_w = 8;

    // Queue index width and the buffer depth that follows from it
    localparam int qidx_w    = 8;
    localparam int buf_depth = 2 ** qidx_w;

    // Transmit buffer window, one byte per address
    localparam logic [addr_w-1:0] tx_buf_base = 32'hff00_0000;
    localparam logic [addr_w-1:0] tx_buf_last = 32'hff00_00ff;

    // Tail is written by the CPU to release bytes for sending
    localparam logic [addr_w-1:0] tx_tail_addr = 32'hff00_0100;

    // Head is advanced by hardware and is read-only for the CPU
    localparam logic [addr_w-1:0] tx_head_addr = 32'hff00_0101;

endpackage

// File: rtl/data_memory.sv
/*
  CPU data memory with the UART transmit queue mapped into its address space.
  Reads have one cycle of latency and writes take effect on the sampling edge.
  RAM words are stored byte-swapped and swapped back on read.
  Byte-enable writes are not supported, and a buffer write keeps only wdata[7:0].
  Writes to the head address are dropped. The tail is not checked against the head.
*/
module data_memory
    import soc_mem_pkg::*;
#(
    parameter int memory_words = 2048
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_start,
    input  logic              cmd_write,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    output logic              rdata_valid,
    input  logic [qidx_w-1:0] q_index,
    output logic [byte_w-1:0] q_byte,
    input  logic [qidx_w-1:0] head,
    output logic [qidx_w-1:0] tail
);

    localparam int word_aw = (memory_words > 1) ? $clog2(memory_words) : 1;

    logic [data_w-1:0] ram [memory_words];
    logic [byte_w-1:0] tx_buf [buf_depth];

    logic               in_buf;
    logic               is_tail;
    logic               is_head;
    logic [word_aw-1:0] word_idx;
    logic [qidx_w-1:0]  buf_idx;
    logic               rd_cmd;
    logic               wr_cmd;

    // Reverses the byte order of one bus word
    function automatic logic [data_w-1:0] byte_swap(input logic [data_w-1:0] w);
        logic [data_w-1:0] r;
        for (int i = 0; i < data_w / byte_w; i++) begin
            r[i*byte_w +: byte_w] = w[data_w-(i+1)*byte_w +: byte_w];
        end
        return r;
    endfunction

    assign rd_cmd = cmd_start && !cmd_write;
    assign wr_cmd = cmd_start && cmd_write;

    // Address decode into buffer, queue registers and RAM
    assign in_buf  = (addr >= tx_buf_base) && (addr <= tx_buf_last);
    assign is_tail = (addr == tx_tail_addr);
    assign is_head = (addr == tx_head_addr);

    // Word index wraps modulo the RAM depth
    assign word_idx = word_aw'((addr >> 2) % memory_words);
    assign buf_idx  = addr[qidx_w-1:0];

    // RAM and buffer storage with the CPU read path
    always_ff @(posedge clk) begin
        if (wr_cmd) begin
            if (in_buf) begin
                tx_buf[buf_idx] <= wdata[byte_w-1:0];
            end else if (!is_tail && !is_head) begin
                ram[word_idx] <= byte_swap(wdata);
            end
        end

        if (rd_cmd) begin
            if (in_buf) begin
                rdata <= {{(data_w-byte_w){1'b0}}, tx_buf[buf_idx]};
            end else if (is_tail) begin
                rdata <= {{(data_w-qidx_w){1'b0}}, tail};
            end else if (is_head) begin
                rdata <= {{(data_w-qidx_w){1'b0}}, head};
            end else begin
                rdata <= byte_swap(ram[word_idx]);
            end
        end
    end

    // Second buffer port, used by the queue reader
    always_ff @(posedge clk) begin
        q_byte <= tx_buf[q_index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail        <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd_cmd;
            if (wr_cmd && is_tail) begin
                tail <= wdata[qidx_w-1:0];
            end
        end
    end

    // A valid read result only ever follows a read command by one cycle
    assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> $past(cmd_start && !cmd_write));

endmodule

// File: rtl/uart_tx_queue_reader.sv
/*
  Drains the transmit queue one byte at a time from head up to tail.
  The buffer read port has one cycle of latency, so tx_start follows the
  fetch by one cycle. Head advances when the serializer drops busy.
  A tail written past the head is not detected.
*/
module uart_tx_queue_reader
    import soc_mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [qidx_w-1:0] tail,
    output logic [qidx_w-1:0] head,
    output logic [qidx_w-1:0] q_index,
    input  logic [byte_w-1:0] q_byte,
    output logic              tx_start,
    output logic [byte_w-1:0] tx_data,
    input  logic              busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_send_wait
    } state_t;

    state_t state;
    logic   busy_seen;

    // The buffer is always addressed at the current head
    assign q_index = head;

    // q_byte holds the byte at head during the fetch cycle
    assign tx_start = (state == st_fetch);
    assign tx_data  = q_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            head      <= '0;
            busy_seen <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (head != tail) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    busy_seen <= 1'b0;
                    state     <= st_send_wait;
                end
                st_send_wait: begin
                    if (busy) begin
                        busy_seen <= 1'b1;
                    end else if (busy_seen) begin
                        // Frame done, head wraps modulo the buffer depth
                        head      <= head + 1'b1;
                        busy_seen <= 1'b0;
                        state     <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) tx_start |-> !busy);

endmodule

// File: rtl/uart_tx_serializer.sv
/*
  8N1 transmitter with one start bit, eight data bits LSB first and one stop bit.
  A frame lasts exactly 10 * clks_per_bit cycles, and busy is high from the
  cycle after tx_start until the stop bit ends.
  tx_start is ignored while busy is high. clks_per_bit must be at least 1.
*/
module uart_tx_serializer
    import soc_mem_pkg::*;
#(
    parameter int clks_per_bit = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              tx_start,
    input  logic [byte_w-1:0] tx_data,
    output logic              busy,
    output logic              tx
);

    localparam int cnt_w   = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int frame_w = byte_w + 2;

    logic [cnt_w-1:0]   baud_cnt;
    logic [3:0]         bit_cnt;
    logic [frame_w-2:0] frame;
    logic               bit_end;

    assign bit_end = (baud_cnt == cnt_w'(clks_per_bit - 1));

    // Holds the data and stop bits that follow the start bit with the next one in bit 0
    always_ff @(posedge clk) begin
        if (!busy && tx_start) begin
            frame <= {1'b1, tx_data};
        end else if (busy && bit_end) begin
            frame <= {1'b1, frame[frame_w-2:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            tx       <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (tx_start) begin
                // Start bit goes out right away
                busy     <= 1'b1;
                tx       <= 1'b0;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else begin
            if (bit_end) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'(frame_w - 1)) begin
                    busy <= 1'b0;
                    tx   <= 1'b1;
                end else begin
                    tx      <= frame[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // Line idles high between frames
    assert property (@(posedge clk) disable iff (rst) !busy |-> tx);

endmodule

// File: rtl/uart_mmio_top.sv
/*
  Data memory with a memory-mapped UART transmit queue and its 8N1 drain path.
  cmd_ready is tied high, there is no handshake on the command port.
  Transmit only: no receive path, parity or flow control.
*/
module uart_mmio_top
    import soc_mem_pkg::*;
#(
    parameter int memory_words = 2048,
    parameter int clks_per_bit = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_start,
    input  logic              cmd_write,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic              cmd_ready,
    output logic [data_w-1:0] rdata,
    output logic              rdata_valid,
    output logic              tx
);

    logic [qidx_w-1:0] tail;
    logic [qidx_w-1:0] head;
    logic [qidx_w-1:0] q_index;
    logic [byte_w-1:0] q_byte;
    logic              tx_start;
    logic [byte_w-1:0] tx_data;
    logic              busy;

    assign cmd_ready = 1'b1;

    data_memory #(
        .memory_words(memory_words)
    ) u_data_memory (
        .clk        (clk),
        .rst        (rst),
        .cmd_start  (cmd_start),
        .cmd_write  (cmd_write),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .rdata_valid(rdata_valid),
        .q_index    (q_index),
        .q_byte     (q_byte),
        .head       (head),
        .tail       (tail)
    );

    uart_tx_queue_reader u_queue_reader (
        .clk     (clk),
        .rst     (rst),
        .tail    (tail),
        .head    (head),
        .q_index (q_index),
        .q_byte  (q_byte),
        .tx_start(tx_start),
        .tx_data (tx_data),
        .busy    (busy)
    );

    uart_tx_serializer #(
        .clks_per_bit(clks_per_bit)
    ) u_serializer (
        .clk     (clk),
        .rst     (rst),
        .tx_start(tx_start),
        .tx_data (tx_data),
        .busy    (busy),
        .tx      (tx)
    );

endmodule

// File: sim/tb_uart_mmio.sv
/*
  Testbench for uart_mmio_top, driven by sim/uart_mmio_vectors.txt.
  The vector path is relative to the project root, so run from there.
  The serial decoder assumes clks_per_bit is even and matches the DUT setting.
  F and C vector lines use a fill pattern computed from the buffer slot.
*/
module tb_uart_mmio
    import soc_mem_pkg::*;
;

    localparam int    memory_words    = 2048;
    localparam int    clks_per_bit    = 4;
    localparam int    valid_timeout   = 8;
    localparam int    byte_timeout    = 20 * 10 * clks_per_bit;
    localparam int    head_poll_limit = 400;
    localparam string vector_file     = "sim/uart_mmio_vectors.txt";

    logic              clk;
    logic              rst;
    logic              cmd_start;
    logic              cmd_write;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              cmd_ready;
    logic [data_w-1:0] rdata;
    logic              rdata_valid;
    logic              tx;

    // Bytes seen on the serial line in the order they arrived
    logic [7:0] rx_q [$];

    uart_mmio_top #(
        .memory_words(memory_words),
        .clks_per_bit(clks_per_bit)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .cmd_start  (cmd_start),
        .cmd_write  (cmd_write),
        .addr       (addr),
        .wdata      (wdata),
        .cmd_ready  (cmd_ready),
        .rdata      (rdata),
        .rdata_valid(rdata_valid),
        .tx         (tx)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    // Pattern byte for a buffer slot that depends on every bit of the slot
    function automatic logic [7:0] fill_byte(input logic [7:0] slot);
        return (slot * 8'd29) ^ 8'h5c;
    endfunction

    task automatic cpu_write(input logic [31:0] a, input logic [31:0] d, input string name);
        @(posedge clk);
        cmd_start <= 1'b1;
        cmd_write <= 1'b1;
        addr      <= a;
        wdata     <= d;
        @(posedge clk);
        cmd_start <= 1'b0;
        cmd_write <= 1'b0;
        @(negedge clk);
        check_value({name, "_no_valid"}, 32'd0, {31'b0, rdata_valid});
        check_value({name, "_ready"}, 32'd1, {31'b0, cmd_ready});
    endtask

    task automatic cpu_read(input logic [31:0] a, input string name,
                            output logic [31:0] value);
        int lat;
        @(posedge clk);
        cmd_start <= 1'b1;
        cmd_write <= 1'b0;
        addr      <= a;
        @(posedge clk);
        cmd_start <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > valid_timeout) begin
                fail_run({"Timed out waiting for rdata_valid in ", name});
            end
        end while (!rdata_valid);
        // Result must show up in the cycle right after the sampling edge
        check_value({name, "_latency"}, 32'd1, lat);
        check_value({name, "_ready"}, 32'd1, {31'b0, cmd_ready});
        value = rdata;
    endtask

    task automatic wait_serial_byte(input string name, output logic [7:0] b);
        int waited;
        waited = 0;
        while (rx_q.size() == 0) begin
            @(negedge clk);
            waited++;
            if (waited > byte_timeout) begin
                fail_run({"Timed out waiting for a serial byte in ", name});
            end
        end
        b = rx_q.pop_front();
    endtask

    task automatic poll_head(input logic [31:0] a, input logic [31:0] expected,
                             input string name);
        logic [31:0] got;
        int          polls;
        polls = 0;
        cpu_read(a, name, got);
        while (got !== expected) begin
            polls++;
            if (polls > head_poll_limit) begin
                fail_run($sformatf("Timed out polling head in %s, last value %0h", name, got));
            end
            cpu_read(a, name, got);
        end
    endtask

    task automatic fill_buffer(input logic [7:0] first, input logic [31:0] count,
                               input string name);
        logic [7:0] slot;
        for (int i = 0; i < count; i++) begin
            slot = first + 8'(i);
            cpu_write(tx_buf_base | {24'b0, slot}, {24'b0, fill_byte(slot)}, name);
        end
    endtask

    task automatic check_fill_bytes(input logic [7:0] first, input logic [31:0] count,
                                    input string name);
        logic [7:0] slot;
        logic [7:0] b;
        for (int i = 0; i < count; i++) begin
            slot = first + 8'(i);
            wait_serial_byte(name, b);
            check_value($sformatf("%s_slot%0d", name, slot),
                        {24'b0, fill_byte(slot)}, {24'b0, b});
        end
    endtask

    // Samples each bit in its middle, starting from the falling edge of the start bit
    always begin : serial_decoder
        logic [7:0] b;
        @(negedge clk);
        if (!rst && tx === 1'b0) begin
            repeat (clks_per_bit / 2) @(negedge clk);
            check_value("start_bit", 32'd0, {31'b0, tx});
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge clk);
                b[i] = tx;
            end
            repeat (clks_per_bit) @(negedge clk);
            check_value("stop_bit", 32'd1, {31'b0, tx});
            rx_q.push_back(b);
        end
    end

    initial begin : main_flow
        int          fd;
        int          n;
        string       line;
        string       op;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] got;
        logic [7:0]  b;
        clk       = 1'b0;
        rst       = 1'b1;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        addr      = '0;
        wdata     = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Line has to idle high with no command issued yet
        repeat (16) begin
            @(negedge clk);
            check_value("tx_idle_after_reset", 32'd1, {31'b0, tx});
        end

        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            fail_run({"Could not open the vector file ", vector_file});
        end

        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %s", op, a, d, name);
            if (n != 4) begin
                fail_run({"Malformed vector line: ", line});
            end
            if (op == "W") begin
                cpu_write(a, d, name);
            end else if (op == "R") begin
                cpu_read(a, name, got);
                check_value(name, d, got);
            end else if (op == "U") begin
                wait_serial_byte(name, b);
                check_value(name, d, {24'b0, b});
            end else if (op == "H") begin
                poll_head(a, d, name);
            end else if (op == "F") begin
                fill_buffer(a[7:0], d, name);
            end else if (op == "C") begin
                check_fill_bytes(a[7:0], d, name);
            end else begin
                fail_run({"Unknown op in vector line: ", line});
            end
        end
        $fclose(fd);

        check_value("unexpected_serial_bytes", 32'd0, 32'(rx_q.size()));
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: sim/uart_mmio_vectors.txt
# op addr data name, addr and data in hex
# W write, R read and compare, U next serial byte, H poll head until equal to data
# F fills buffer slots with the pattern and C checks them on the line, addr = first slot, data = count
R ff000101 00000000 head_after_reset
R ff000100 00000000 tail_after_reset
W 00000040 11223344 ram_write
R 00000040 11223344 ram_readback
R 00002040 11223344 ram_alias_read
W 00002044 cafef00d ram_alias_write
R 00000044 cafef00d ram_alias_readback
W ff000010 aabbcc5a buf_low_byte
R ff000010 0000005a buf_zero_extend
W ff000101 00000077 head_write_ignored
R ff000101 00000000 head_unchanged
W ff000000 00000048 hi_slot0
W ff000001 00000069 hi_slot1
W ff000002 00000021 hi_slot2
R ff000001 00000069 hi_slot1_readback
W ff000100 00000003 hi_tail
U 00000000 00000048 hi_byte0
U 00000000 00000069 hi_byte1
U 00000000 00000021 hi_byte2
H ff000101 00000003 hi_head
R ff000100 00000003 hi_tail_readback
F 00000003 000000ff wrap_fill
W ff000100 00000002 wrap_tail
C 00000003 000000ff wrap_bytes
H ff000101 00000002 wrap_head
R ff000100 00000002 wrap_tail_readback
R 00000040 11223344 ram_after_queue
R 00000044 cafef00d ram_alias_after_queue

// File: sources.f
rtl/soc_mem_pkg.sv
rtl/data_memory.sv
rtl/uart_tx_queue_reader.sv
rtl/uart_tx_serializer.sv
rtl/uart_mmio_top.sv
sim/tb_uart_mmio.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it from the project root
# and decides pass or fail by searching the log for the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir "$log" || exit 1

verilator --binary --timing --assert --top-module tb_uart_mmio \
    -f sources.f -o sim_uart_mmio \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_uart_mmio > "$log" 2>&1
cat "$log"

grep -qF 'All tests passed!' "$log" && echo "PASS" || { echo "FAIL"; exit 1; }
